// ==== all.f ====
src/uart_pkg.sv
src/echo_pkg.sv
src/line_buf_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/gap_timer.sv
src/line_buffer.sv
src/echo_ctrl.sv
src/uart_echo_top.sv
dv/echo_checker.sv
dv/tb_uart_echo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the echo testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module tb_uart_echo -o tb_uart_echo \
	&& ./obj_dir/tb_uart_echo > sim.log 2>&1 || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// ==== dv/tb_uart_echo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART line echo testbench top
// clock, reset, LFSR stimulus, serial driver, reply model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_uart_echo;

	localparam int CLKS_PER_BIT = 8;
	localparam int GAP_CLKS     = 200;
	localparam int BUF_DEPTH    = 16;
	localparam int REPLY_WAIT   = 4000; // clocks

	logic        sys_clk;
	logic        sys_rst_n;
	logic        uart_rx_pin;
	logic        uart_tx_pin;
	logic        busy;
	logic [31:0] lfsr_q = 32'hd5e0954b;
	logic [7:0]  line_q[$];
	bit          bad_q[$];  // force a low stop bit on this byte
	bit          aborted      = 1'b0;
	int          tb_errs      = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	int          errs_before  = 0;

	uart_echo_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.GAP_CLKS     (GAP_CLKS),
		.BUF_DEPTH    (BUF_DEPTH)
	) u_dut (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.uart_rx_pin (uart_rx_pin),
		.uart_tx_pin (uart_tx_pin),
		.busy        (busy)
	);

	echo_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_chk (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_pin    (uart_tx_pin)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
			r      = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic int total_errs();
		return tb_errs + u_chk.err_cnt;
	endfunction

	task automatic send_byte(input logic [7:0] b, input bit bad_stop);
		@(negedge sys_clk);
		uart_rx_pin = 1'b0; // start bit
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_pin = b[i];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		uart_rx_pin = !bad_stop;
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		uart_rx_pin = 1'b1;
		if (bad_stop)
			repeat (CLKS_PER_BIT) @(negedge sys_clk); // one idle bit to recover
	endtask

	task automatic fill_random(input int n);
		logic [31:0] r;
		line_q.delete();
		bad_q.delete();
		for (int i = 0; i < n; i++) begin
			r = rand_bits(8);
			line_q.push_back(r[7:0]);
			bad_q.push_back(1'b0);
		end
	endtask

	task automatic send_line();
		foreach (line_q[i])
			send_byte(line_q[i], bad_q[i]);
	endtask

	// "&&", first BUF_DEPTH good bytes, CR LF
	task automatic expect_line();
		int kept;
		kept = 0;
		u_chk.push_expected(8'h26);
		u_chk.push_expected(8'h26);
		foreach (line_q[i]) begin
			if (!bad_q[i] && kept < BUF_DEPTH) begin
				u_chk.push_expected(line_q[i]);
				kept++;
			end
		end
		u_chk.push_expected(8'h0D);
		u_chk.push_expected(8'h0A);
	endtask

	task automatic wait_reply();
		int cnt;
		cnt = 0;
		while (!aborted && (u_chk.pending() != 0 || busy) && cnt < REPLY_WAIT) begin
			@(negedge sys_clk);
			cnt++;
		end
		if (cnt >= REPLY_WAIT) begin
			$display("timeout: reply still running after %0d clocks", REPLY_WAIT);
			aborted = 1'b1;
		end
	endtask

	task automatic wait_busy();
		int cnt;
		cnt = 0;
		while (!aborted && !busy && cnt < 1000) begin
			@(negedge sys_clk);
			cnt++;
		end
		if (!aborted && !busy) begin
			$display("timeout: busy never rose after the line");
			aborted = 1'b1;
		end
	endtask

	task automatic run_line();
		send_line();
		expect_line();
		wait_reply();
		repeat (300) @(negedge sys_clk); // gap between lines
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (aborted || total_errs() != errs_before) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: passed", tests_run, name);
		end
		errs_before = total_errs();
	endtask

	initial begin
		logic [31:0] len;
		sys_rst_n   = 1'b0;
		uart_rx_pin = 1'b1;
		repeat (4) @(negedge sys_clk);
		sys_rst_n = 1'b1;

		repeat (300) begin
			@(negedge sys_clk);
			if (uart_tx_pin !== 1'b1 || busy !== 1'b0) begin
				$display("[ERROR] %0t: idle tx pin %b busy %b", $time, uart_tx_pin, busy);
				tb_errs++;
			end
		end
		if (u_chk.frame_cnt != 0) begin
			$display("[ERROR] %0t: %0d frames sent while idle", $time, u_chk.frame_cnt);
			tb_errs++;
		end
		end_test("idle after reset");

		fill_random(1);
		run_line();
		end_test("single byte");

		for (int n = 0; n < 10; n++) begin
			len = rand_bits(4);
			fill_random(int'(len[3:0]) + 1);
			run_line();
		end
		end_test("ten random lines");

		fill_random(20);
		run_line();
		end_test("overflow line");

		fill_random(6);
		bad_q[2] = 1'b1;
		run_line();
		end_test("bad stop bit");

		fill_random(3);
		send_line();
		expect_line();
		wait_busy();
		fill_random(2); // these arrive during the reply
		send_line();
		if (!aborted && !busy) begin
			$display("busy fell before the ignored bytes ended, test not valid");
			tb_errs++;
		end
		wait_reply();
		repeat (300) @(negedge sys_clk);
		fill_random(2);
		run_line();
		end_test("bytes during reply");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
		         total_errs());
		if (!aborted && total_errs() == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== dv/echo_checker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reply monitor, decodes the UART transmit pin at mid-bit
// compares each byte with the queued expected reply
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module echo_checker #(
	parameter int CLKS_PER_BIT = 8,
	parameter int STALL_LIMIT  = 1500 // clocks with bytes pending and none arriving
) (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic tx_pin
);

	logic [7:0] exp_q[$];
	int         err_cnt   = 0;
	int         frame_cnt = 0;
	int         seen_cnt  = 0;
	int         stall     = 0;

	function automatic void push_expected(input logic [7:0] b);
		exp_q.push_back(b);
	endfunction

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic compare_byte(input logic [7:0] got);
		logic [7:0] want;
		if (exp_q.size() == 0) begin
			$display("unexpected byte %02h on the transmit pin at %0t, no reply pending",
			         got, $time);
			err_cnt++;
		end else begin
			want = exp_q.pop_front();
			if (got !== want) begin
				$display("[ERROR] %0t: reply byte %02h, expected %02h", $time, got, want);
				err_cnt++;
			end
		end
	endtask

	// frame decoder on falling edges, pin is stable there
	always begin : decode
		logic [7:0] shreg;
		@(negedge sys_clk);
		if (sys_rst_n && tx_pin == 1'b0) begin
			repeat (CLKS_PER_BIT / 2) @(negedge sys_clk); // middle of start bit
			if (tx_pin == 1'b0) begin
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge sys_clk);
					shreg[i] = tx_pin; // LSB first
				end
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				frame_cnt++;
				if (tx_pin !== 1'b1) begin
					$display("framing error on the transmit pin at %0t, stop bit low", $time);
					err_cnt++;
				end
				compare_byte(shreg);
			end
		end
	end

	// missing reply watchdog
	always @(posedge sys_clk) begin
		if (exp_q.size() == 0 || frame_cnt != seen_cnt) begin
			stall    = 0;
			seen_cnt = frame_cnt;
		end else if (stall == STALL_LIMIT) begin
			$display("missing reply: %0d expected bytes never appeared on the transmit pin",
			         exp_q.size());
			err_cnt++;
			exp_q.delete();
			stall = 0;
		end else begin
			stall++;
		end
	end

endmodule

// ==== src/uart_echo_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART line echo top level
// receiver, gap timer, line buffer, controller, transmitter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_echo_top #(
	parameter int CLKS_PER_BIT = 434,
	parameter int GAP_CLKS     = 50000,
	parameter int BUF_DEPTH    = 64     // power of two
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic uart_rx_pin,
	output logic uart_tx_pin,
	output logic busy
);

	logic [7:0]           rx_data;
	uart_pkg::rx_status_t rx_status;
	logic                 gap_run;
	logic                 gap_restart;
	logic                 gap_expired;
	logic                 tx_start;
	logic [7:0]           tx_data;
	logic                 tx_ready;

	line_buf_if #(.BUF_DEPTH(BUF_DEPTH)) lb_if ();

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_pin    (uart_rx_pin),
		.rx_data   (rx_data),
		.rx_status (rx_status)
	);

	gap_timer #(.GAP_CLKS(GAP_CLKS)) u_gap (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.gap_run     (gap_run),
		.gap_restart (gap_restart),
		.gap_expired (gap_expired)
	);

	line_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.lb        (lb_if.buffer)
	);

	echo_ctrl u_ctrl (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_data     (rx_data),
		.rx_status   (rx_status),
		.gap_expired (gap_expired),
		.tx_ready    (tx_ready),
		.gap_run     (gap_run),
		.gap_restart (gap_restart),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.busy        (busy),
		.lb          (lb_if.ctrl)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_start  (tx_start),
		.tx_data   (tx_data),
		.tx_pin    (uart_tx_pin),
		.tx_ready  (tx_ready)
	);

endmodule

// ==== src/echo_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// echo controller FSM
// collects bytes, then sends "&&" + line + CR LF
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module echo_ctrl (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [7:0]           rx_data,
	input  uart_pkg::rx_status_t rx_status,
	input  logic                 gap_expired,
	input  logic                 tx_ready,
	output logic                 gap_run,
	output logic                 gap_restart,
	output logic                 tx_start,
	output logic [7:0]           tx_data,
	output logic                 busy,
	line_buf_if.ctrl             lb
);

	echo_pkg::echo_state_t state;
	logic                  sub_idx; // which of the two head / tail bytes
	logic                  accept;
	logic                  rx_good;
	logic                  tx_free;
	logic                  tx_load;
	logic [7:0]            tx_byte;

	assign accept  = (state == echo_pkg::ST_IDLE) || (state == echo_pkg::ST_COLLECT);
	assign rx_good = (rx_status == uart_pkg::RX_GOOD);
	// ready stays high during the strobe cycle itself
	assign tx_free = tx_ready && !tx_start;

	assign lb.wr_en   = accept && rx_good; // frame errors never stored
	assign lb.wr_data = rx_data;
	assign lb.clear   = (state == echo_pkg::ST_DONE) && tx_free;

	assign gap_run     = (state == echo_pkg::ST_COLLECT);
	assign gap_restart = accept && rx_good;
	assign busy        = !accept;

	// next reply byte and when it goes out
	always_comb begin
		tx_load = 1'b0;
		tx_byte = echo_pkg::MARK_CHAR;
		case (state)
			echo_pkg::ST_SEND_HEAD: tx_load = tx_free;
			echo_pkg::ST_SEND_BODY: begin
				tx_load = tx_free && (lb.rd_idx != lb.count);
				tx_byte = lb.rd_data;
			end
			echo_pkg::ST_SEND_TAIL: begin
				tx_load = tx_free;
				tx_byte = sub_idx ? echo_pkg::LF_CHAR : echo_pkg::CR_CHAR;
			end
			default: tx_load = 1'b0;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= echo_pkg::ST_IDLE;
			sub_idx   <= 1'b0;
			tx_start  <= 1'b0;
			lb.rd_idx <= '0;
		end else begin
			tx_start <= tx_load;
			case (state)
				echo_pkg::ST_IDLE: begin
					if (rx_good)
						state <= echo_pkg::ST_COLLECT;
				end
				echo_pkg::ST_COLLECT: begin
					sub_idx <= 1'b0;
					if (gap_expired)
						state <= echo_pkg::ST_SEND_HEAD;
				end
				echo_pkg::ST_SEND_HEAD: begin
					if (tx_load) begin
						sub_idx <= ~sub_idx;
						if (sub_idx) begin
							state     <= echo_pkg::ST_SEND_BODY;
							lb.rd_idx <= '0;
						end
					end
				end
				echo_pkg::ST_SEND_BODY: begin
					if (lb.rd_idx == lb.count)
						state <= echo_pkg::ST_SEND_TAIL; // sub_idx back to 0 here
					else if (tx_load)
						lb.rd_idx <= lb.rd_idx + 1'b1;
				end
				echo_pkg::ST_SEND_TAIL: begin
					if (tx_load) begin
						sub_idx <= ~sub_idx;
						if (sub_idx)
							state <= echo_pkg::ST_DONE;
					end
				end
				default: begin // done, wait for LF to leave the pin
					if (tx_free)
						state <= echo_pkg::ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tx_load)
			tx_data <= tx_byte;
	end

endmodule

// ==== src/line_buffer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line byte storage with saturating write count
// indexed combinational read, one clock clear
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module line_buffer #(
	parameter int BUF_DEPTH = 64
) (
	input logic        sys_clk,
	input logic        sys_rst_n,
	line_buf_if.buffer lb
);

	localparam int AW = $clog2(BUF_DEPTH);
	localparam logic [AW:0] FULL_CNT = (AW+1)'(BUF_DEPTH);

	logic [uart_pkg::DATA_BITS-1:0] mem [BUF_DEPTH];
	logic                           wr_ok;

	assign wr_ok = lb.wr_en && !lb.clear && (lb.count != FULL_CNT); // overflow drops

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			lb.count <= '0;
		else if (lb.clear)
			lb.count <= '0;
		else if (wr_ok)
			lb.count <= lb.count + 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (wr_ok)
			mem[lb.count[AW-1:0]] <= lb.wr_data;
	end

	assign lb.rd_data = mem[lb.rd_idx[AW-1:0]];

endmodule

// ==== src/gap_timer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// restartable idle gap timer, one pulse per quiet period
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module gap_timer #(
	parameter int GAP_CLKS = 50000
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic gap_run,
	input  logic gap_restart,
	output logic gap_expired
);

	localparam int GW = $clog2(GAP_CLKS + 1);
	localparam logic [GW-1:0] GAP_TERM = GW'(GAP_CLKS);
	localparam logic [GW-1:0] GAP_LAST = GW'(GAP_CLKS - 1);

	logic [GW-1:0] gap_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			gap_cnt     <= '0;
			gap_expired <= 1'b0;
		end else begin
			gap_expired <= gap_run && !gap_restart && (gap_cnt == GAP_LAST);
			if (!gap_run || gap_restart)
				gap_cnt <= '0;
			else if (gap_cnt != GAP_TERM) // parks at terminal, no repeat pulse
				gap_cnt <= gap_cnt + 1'b1;
		end
	end

endmodule

// ==== src/uart_tx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmitter, 8N1, LSB first
// start strobe in, ready level while idle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx_pin,
	output logic       tx_ready
);

	localparam int FW = uart_pkg::DATA_BITS + 2; // start + data + stop
	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam int NW = $clog2(FW);
	localparam logic [CW-1:0] BIT_END  = CW'(CLKS_PER_BIT - 1);
	localparam logic [NW-1:0] LAST_BIT = NW'(FW - 1);

	logic          busy_q;
	logic [FW-1:0] shift_q;
	logic [CW-1:0] clk_cnt;
	logic [NW-1:0] bit_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy_q  <= 1'b0;
			shift_q <= {FW{uart_pkg::LINE_IDLE}}; // holds the pin at idle
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy_q) begin
			if (tx_start) begin
				busy_q  <= 1'b1;
				shift_q <= {uart_pkg::LINE_IDLE, tx_data, ~uart_pkg::LINE_IDLE};
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == BIT_END) begin
			clk_cnt <= '0;
			shift_q <= {uart_pkg::LINE_IDLE, shift_q[FW-1:1]};
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == LAST_BIT)
				busy_q <= 1'b0; // stop bit fully sent
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign tx_pin   = shift_q[0];
	assign tx_ready = ~busy_q;

endmodule

// ==== src/uart_rx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oversampled UART receiver, 8N1, LSB first
// start bit confirmed at mid-bit, stop bit checked
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 rx_pin,
	output logic [7:0]           rx_data,
	output uart_pkg::rx_status_t rx_status
);

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam int BW = $clog2(uart_pkg::DATA_BITS);
	localparam logic [CW-1:0] BIT_END  = CW'(CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF_END = CW'(CLKS_PER_BIT / 2 - 1);
	localparam logic [BW-1:0] LAST_BIT = BW'(uart_pkg::DATA_BITS - 1);

	localparam logic [1:0] S_HUNT  = 2'd0,
	                       S_START = 2'd1,
	                       S_DATA  = 2'd2,
	                       S_STOP  = 2'd3;

	logic          rx_meta;
	logic          rx_sync;
	logic          rx_prev;
	logic [1:0]    state;
	logic [CW-1:0] clk_cnt;
	logic [BW-1:0] bit_idx;
	logic [7:0]    shift_q;

	// two flop synchroniser plus edge history
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= uart_pkg::LINE_IDLE;
			rx_sync <= uart_pkg::LINE_IDLE;
			rx_prev <= uart_pkg::LINE_IDLE;
		end else begin
			rx_meta <= rx_pin;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= S_HUNT;
			clk_cnt   <= '0;
			bit_idx   <= '0;
			rx_status <= uart_pkg::RX_NONE;
		end else begin
			rx_status <= uart_pkg::RX_NONE;
			case (state)
				S_HUNT: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync) // falling edge only
						state <= S_START;
				end
				S_START: begin
					if (clk_cnt == HALF_END) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// glitch shorter than half a bit goes back to hunting
						state   <= (rx_sync == uart_pkg::LINE_IDLE) ? S_HUNT : S_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (clk_cnt == BIT_END) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_BIT)
							state <= S_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin // S_STOP
					if (clk_cnt == BIT_END) begin
						clk_cnt   <= '0;
						state     <= S_HUNT;
						rx_status <= (rx_sync == uart_pkg::LINE_IDLE) ?
						             uart_pkg::RX_GOOD : uart_pkg::RX_FRAME_ERR;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// data bits shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && clk_cnt == BIT_END)
			shift_q <= {rx_sync, shift_q[7:1]};
	end

	assign rx_data = shift_q;

endmodule

// ==== src/line_buf_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line buffer access bundle, controller and storage views
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface line_buf_if #(
	parameter int BUF_DEPTH = 64
);

	localparam int AW = $clog2(BUF_DEPTH);

	logic          wr_en;
	logic [7:0]    wr_data;
	logic          clear;   // empties buffer on next clock
	logic [AW:0]   count;   // 0 .. BUF_DEPTH
	logic [AW:0]   rd_idx;  // same width as count for end compare
	logic [7:0]    rd_data; // combinational from rd_idx

	modport ctrl (
		output wr_en, wr_data, clear, rd_idx,
		input  count, rd_data
	);

	modport buffer (
		input  wr_en, wr_data, clear, rd_idx,
		output count, rd_data
	);

endinterface

// ==== src/echo_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reply framing characters
// echo controller state encoding
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package echo_pkg;

	// reply is "&&" + body + CR LF
	localparam logic [7:0] MARK_CHAR = 8'h26;
	localparam logic [7:0] CR_CHAR   = 8'h0D;
	localparam logic [7:0] LF_CHAR   = 8'h0A;

	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_COLLECT   = 3'd1, // line open, gap timer running
		ST_SEND_HEAD = 3'd2,
		ST_SEND_BODY = 3'd3,
		ST_SEND_TAIL = 3'd4,
		ST_DONE      = 3'd5  // last frame draining, then clear
	} echo_state_t;

endpackage

// ==== src/uart_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial frame constants shared by receiver and transmitter
// receive status encoding
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_pkg;

	// 8N1 frames only
	localparam int DATA_BITS = 8;

	localparam logic LINE_IDLE = 1'b1; // mark level

	// outcome of one received frame
	typedef enum logic [1:0] {
		RX_NONE      = 2'd0,
		RX_GOOD      = 2'd1,
		RX_FRAME_ERR = 2'd2 // stop bit sampled low
	} rx_status_t;

endpackage
